// File: hw/noc_alloc_config.svh
`ifndef NOC_ALLOC_CONFIG_SVH
`define NOC_ALLOC_CONFIG_SVH

// router geometry

// number of router ports, local port included
`define NOC_P 5

// virtual channels per port
`define NOC_V 4

// derived sizes

// no self loop, so an input never targets its own port
`define NOC_P_1 (`NOC_P - 1)

// IVC count of the whole router, IVC number = port * V + vc
`define NOC_PV (`NOC_P * `NOC_V)

`endif

// File: hw/noc_port_pkg.sv
`include "noc_alloc_config.svh"

// port-level vectors used by both allocator stages
package noc_port_pkg;

    // one bit per router port, indexed by port number
    // used for the per-port granted flags
    typedef logic [`NOC_P-1:0] port_vec_t;

    // one-hot destination as seen from a single input port
    // the own port is left out of the code
    //   bit k -> output k      when k <  own port
    //   bit k -> output k + 1  when k >= own port
    // the same width is reused for the request and grant
    // vectors of an output arbiter, where bit k stands for
    // input k below the output and input k + 1 above it
    typedef logic [`NOC_P_1-1:0] dest_port_t;

endpackage

// File: hw/noc_vc_pkg.sv
`include "noc_alloc_config.svh"

// VC-level vectors
package noc_vc_pkg;

    // one bit per VC of a single port
    typedef logic [`NOC_V-1:0] vc_vec_t;

    // one bit per IVC of the router, flat over all ports
    typedef logic [`NOC_PV-1:0] ivc_vec_t;

    // free OVCs of the requested output port that an IVC may take
    typedef logic [`NOC_V-1:0] ovc_mask_t;

endpackage

// File: hw/rr_arbiter.sv
`include "noc_alloc_config.svh"

module rr_arbiter (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [`NOC_V-1:0] request,
    input  logic              priority_en,  // allow the pointer to move this cycle
    output logic [`NOC_V-1:0] grant
);

    logic [`NOC_V-1:0]   prio;     // one-hot, index with highest priority
    logic [2*`NOC_V-1:0] req_dbl;  // request repeated once to wrap around
    logic [2*`NOC_V-1:0] gnt_dbl;

    // subtracting prio clears every requester below the pointer,
    // the upper copy catches the ones that wrapped past the top
    assign req_dbl = {request, request};
    assign gnt_dbl = req_dbl & ~(req_dbl - {{`NOC_V{1'b0}}, prio});
    assign grant   = gnt_dbl[`NOC_V-1:0] | gnt_dbl[2*`NOC_V-1:`NOC_V];

    // pointer moves one past the winner
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prio <= {{(`NOC_V-1){1'b0}}, 1'b1};
        end else if (priority_en && (|grant)) begin
            prio <= {grant[`NOC_V-2:0], grant[`NOC_V-1]};  // rotate left
        end
    end

    // at most one winner, whatever the pointer history
    a_grant_onehot0: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(grant)
    );

    // never grant an index that did not ask
    a_grant_in_request: assert property (
        @(posedge clk) disable iff (!rst_n)
        (grant & ~request) == '0
    );

endmodule

// File: hw/nonspec_sw_alloc.sv
`include "noc_alloc_config.svh"

// input-first separable switch allocator
// stage 1 picks one IVC per input port, stage 2 one input per output port
module nonspec_sw_alloc (
    input  logic                          clk,
    input  logic                          rst_n,
    input  noc_vc_pkg::ivc_vec_t          ivc_request_masked,
    input  noc_port_pkg::dest_port_t      dest_port [`NOC_PV],
    output noc_vc_pkg::vc_vec_t           ivc_grant [`NOC_P],          // input arbiter winner
    output wire noc_port_pkg::dest_port_t granted_dest_port [`NOC_P],
    output noc_vc_pkg::ivc_vec_t          ivc_sw_grant,
    output noc_port_pkg::port_vec_t       any_ivc_granted,             // per input port
    output noc_port_pkg::port_vec_t       any_ovc_granted              // per output port
);

    noc_vc_pkg::vc_vec_t           in_req   [`NOC_P];  // requests split per input port
    noc_port_pkg::dest_port_t      sel_dest [`NOC_P];  // destination of the stage 1 winner
    wire noc_port_pkg::dest_port_t out_req  [`NOC_P];  // indexed by output port
    noc_port_pkg::dest_port_t      out_gnt  [`NOC_P];
    wire noc_port_pkg::port_vec_t  taken    [`NOC_P];  // [output][input], full width

    always_comb begin
        for (int p = 0; p < `NOC_P; p++) begin
            in_req[p] = ivc_request_masked[p*`NOC_V +: `NOC_V];
        end
    end

    // one-hot mux of the winner's destination
    always_comb begin
        for (int p = 0; p < `NOC_P; p++) begin
            sel_dest[p] = '0;
            for (int v = 0; v < `NOC_V; v++) begin
                if (ivc_grant[p][v]) begin
                    sel_dest[p] |= dest_port[p*`NOC_V + v];
                end
            end
        end
    end

    genvar gi;
    genvar gk;
    genvar go;

    generate
        for (gi = 0; gi < `NOC_P; gi++) begin : g_port

            // input stage, pointer only moves when this port won an output
            rr_arbiter u_in_arb (
                .clk         (clk),
                .rst_n       (rst_n),
                .request     (in_req[gi]),
                .priority_en (any_ivc_granted[gi]),
                .grant       (ivc_grant[gi])
            );

            // gi plays both roles here, as output for out_req
            // and as input for granted_dest_port
            // the skip of the own port makes both maps the same shape
            for (gk = 0; gk < `NOC_P_1; gk++) begin : g_remap
                if (gk < gi) begin : g_lo
                    assign out_req[gi][gk]           = sel_dest[gk][gi-1];
                    assign granted_dest_port[gi][gk] = out_gnt[gk][gi-1];
                end else begin : g_hi
                    assign out_req[gi][gk]           = sel_dest[gk+1][gi];
                    assign granted_dest_port[gi][gk] = out_gnt[gk+1][gi];
                end
            end

            // output stage, rotates on every grant
            rr_arbiter u_out_arb (
                .clk         (clk),
                .rst_n       (rst_n),
                .request     (out_req[gi]),
                .priority_en (1'b1),
                .grant       (out_gnt[gi])
            );

            // expand the granted destination back to full port numbering
            for (go = 0; go < `NOC_P; go++) begin : g_taken
                if (go < gi) begin : g_below
                    assign taken[go][gi] = granted_dest_port[gi][go];
                end else if (go > gi) begin : g_above
                    assign taken[go][gi] = granted_dest_port[gi][go-1];
                end else begin : g_self
                    assign taken[go][gi] = 1'b0;
                end
            end
        end
    endgenerate

    always_comb begin
        for (int p = 0; p < `NOC_P; p++) begin
            any_ivc_granted[p] = |granted_dest_port[p];
            any_ovc_granted[p] = |out_gnt[p];
            // stage 1 winner only counts once its port also won stage 2
            ivc_sw_grant[p*`NOC_V +: `NOC_V] = any_ivc_granted[p] ? ivc_grant[p] : '0;
        end
    end

    // after the round trip through both remaps, no output
    // may end up claimed by two input ports
    generate
        for (go = 0; go < `NOC_P; go++) begin : g_out_chk
            a_one_owner: assert property (
                @(posedge clk) disable iff (!rst_n)
                $onehot0(taken[go])
            );
        end
    endgenerate

endmodule

// File: hw/comb_nonspec_alloc.sv
`include "noc_alloc_config.svh"

// combined VC and switch allocator, non-speculative
// an IVC without an OVC only enters switch allocation when a free OVC exists
module comb_nonspec_alloc (
    input  logic                     clk,
    input  logic                     rst_n,
    input  noc_vc_pkg::ivc_vec_t     ivc_req,
    input  noc_vc_pkg::ivc_vec_t     ovc_is_assigned,
    input  noc_vc_pkg::ivc_vec_t     assigned_ovc_not_full,
    input  noc_vc_pkg::ovc_mask_t    masked_ovc_request [`NOC_PV],  // free OVCs at the dest
    input  noc_port_pkg::dest_port_t dest_port [`NOC_PV],
    output noc_vc_pkg::ivc_vec_t     ovc_allocated,                 // output-side OVC number
    output noc_vc_pkg::vc_vec_t      granted_ovc_num [`NOC_PV],
    output noc_vc_pkg::ivc_vec_t     ivc_ovc_grant,
    output noc_port_pkg::dest_port_t granted_dest_port [`NOC_P],
    output noc_vc_pkg::ivc_vec_t     ivc_sw_grant,
    output noc_port_pkg::port_vec_t  any_ivc_granted,
    output noc_port_pkg::port_vec_t  any_ovc_granted
);

    noc_vc_pkg::ivc_vec_t     masked_req;
    noc_vc_pkg::ovc_mask_t    ovc_cand [`NOC_PV];   // one candidate OVC per IVC
    noc_vc_pkg::vc_vec_t      ivc_grant [`NOC_P];   // stage 1 winner per input port
    noc_vc_pkg::ovc_mask_t    cand_sel [`NOC_P];    // candidate of that winner
    noc_port_pkg::port_vec_t  win_assigned;         // winner already owns an OVC
    noc_port_pkg::port_vec_t  new_ovc;              // port hands out a fresh OVC

    // an owned OVC must have room, otherwise some free OVC must exist
    always_comb begin
        for (int n = 0; n < `NOC_PV; n++) begin
            masked_req[n] = (ivc_req[n] & ovc_is_assigned[n] & assigned_ovc_not_full[n])
                          | (|masked_ovc_request[n]);
        end
    end

    genvar gn;

    generate
        for (gn = 0; gn < `NOC_PV; gn++) begin : g_ovc_arb
            rr_arbiter u_ovc_arb (
                .clk         (clk),
                .rst_n       (rst_n),
                .request     (masked_ovc_request[gn]),
                .priority_en (1'b1),
                .grant       (ovc_cand[gn])
            );
        end
    endgenerate

    nonspec_sw_alloc u_sw_alloc (
        .clk                (clk),
        .rst_n              (rst_n),
        .ivc_request_masked (masked_req),
        .dest_port          (dest_port),
        .ivc_grant          (ivc_grant),
        .granted_dest_port  (granted_dest_port),
        .ivc_sw_grant       (ivc_sw_grant),
        .any_ivc_granted    (any_ivc_granted),
        .any_ovc_granted    (any_ovc_granted)
    );

    always_comb begin
        for (int p = 0; p < `NOC_P; p++) begin
            cand_sel[p] = '0;
            for (int v = 0; v < `NOC_V; v++) begin
                if (ivc_grant[p][v]) begin
                    cand_sel[p] |= ovc_cand[p*`NOC_V + v];
                end
            end
            win_assigned[p] = |(ivc_grant[p] & ovc_is_assigned[p*`NOC_V +: `NOC_V]);
            new_ovc[p]      = any_ivc_granted[p] & ~win_assigned[p];

            ivc_ovc_grant[p*`NOC_V +: `NOC_V] = new_ovc[p] ? ivc_grant[p] : '0;
            // every IVC of the port sees the same number
            for (int v = 0; v < `NOC_V; v++) begin
                granted_ovc_num[p*`NOC_V + v] = any_ivc_granted[p] ? cand_sel[p] : '0;
            end
        end
    end

    // mark the OVC taken at the output side
    always_comb begin
        ovc_allocated = '0;
        for (int p = 0; p < `NOC_P; p++) begin
            for (int b = 0; b < `NOC_P_1; b++) begin
                if (new_ovc[p] && granted_dest_port[p][b]) begin
                    if (b < p) begin
                        ovc_allocated[b*`NOC_V +: `NOC_V] |= cand_sel[p];
                    end else begin
                        // skip over the own port
                        ovc_allocated[(b+1)*`NOC_V +: `NOC_V] |= cand_sel[p];
                    end
                end
            end
        end
    end

    // each fresh OVC grant lands on exactly one output-side OVC
    a_alloc_count: assert property (
        @(posedge clk) disable iff (!rst_n)
        $countones(ovc_allocated) == $countones(new_ovc)
    );

    // switch grants come only from requests that passed the mask
    a_grant_masked: assert property (
        @(posedge clk) disable iff (!rst_n)
        (ivc_sw_grant & ~masked_req) == '0
    );

endmodule

// File: verif/tb_clk_gen.sv
module tb_clk_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    // low across the first 4 rising edges
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

// File: verif/alloc_checker.sv
`include "noc_alloc_config.svh"

module alloc_checker (
    input  logic                       clk,
    input  logic                       row_valid,
    input  logic                       rand_valid,
    input  logic                       report_req,
    input  int                         row_id,
    input  noc_vc_pkg::ivc_vec_t       ivc_req,
    input  noc_vc_pkg::ivc_vec_t       ovc_is_assigned,
    input  noc_vc_pkg::ivc_vec_t       assigned_ovc_not_full,
    input  noc_vc_pkg::ovc_mask_t      masked_ovc_request [`NOC_PV],
    input  noc_vc_pkg::ivc_vec_t       ovc_allocated,
    input  noc_vc_pkg::vc_vec_t        granted_ovc_num [`NOC_PV],
    input  noc_vc_pkg::ivc_vec_t       ivc_ovc_grant,
    input  noc_port_pkg::dest_port_t   granted_dest_port [`NOC_P],
    input  noc_vc_pkg::ivc_vec_t       ivc_sw_grant,
    input  noc_port_pkg::port_vec_t    any_ivc_granted,
    input  noc_port_pkg::port_vec_t    any_ovc_granted,
    input  noc_vc_pkg::ivc_vec_t       exp_sw_grant,
    input  noc_vc_pkg::ivc_vec_t       exp_ovc_grant,
    input  noc_vc_pkg::ivc_vec_t       exp_allocated,
    input  logic [`NOC_P*`NOC_P_1-1:0] exp_dest_port,  // one nibble per input port
    input  logic [`NOC_P*`NOC_V-1:0]   exp_ovc_num,    // one nibble per input port
    output int                         error_count
);
    timeunit 1ns;
    timeprecision 100ps;

    int errors = 0;
    int rows_checked = 0;
    int rows_failed = 0;
    int rand_cycles = 0;
    int rand_errors = 0;

    assign error_count = errors;

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want,
                           inout int bad);
        if (got !== want) begin
            $display("FAIL t=%0t %s expected %0h got %0h", $time, name, want, got);
            bad++;
        end
    endtask

    task automatic check_row();
        logic [`NOC_P-1:0] exp_any_ovc;
        int bad;
        bad = 0;
        compare("ivc_sw_grant", 32'(ivc_sw_grant), 32'(exp_sw_grant), bad);
        compare("ivc_ovc_grant", 32'(ivc_ovc_grant), 32'(exp_ovc_grant), bad);
        compare("ovc_allocated", 32'(ovc_allocated), 32'(exp_allocated), bad);
        for (int p = 0; p < `NOC_P; p++) begin
            compare($sformatf("granted_dest_port[%0d]", p), 32'(granted_dest_port[p]),
                    32'(exp_dest_port[p*`NOC_P_1 +: `NOC_P_1]), bad);
            // port counts as granted once it has a destination
            compare($sformatf("any_ivc_granted[%0d]", p), 32'(any_ivc_granted[p]),
                    32'(|exp_dest_port[p*`NOC_P_1 +: `NOC_P_1]), bad);
        end
        exp_any_ovc = '0;
        for (int i = 0; i < `NOC_P; i++) begin
            for (int k = 0; k < `NOC_P_1; k++) begin
                // bit k of input i names output k below i and output k + 1 from i upward
                if (exp_dest_port[i*`NOC_P_1 + k]) begin
                    exp_any_ovc[(k < i) ? k : k + 1] = 1'b1;
                end
            end
        end
        compare("any_ovc_granted", 32'(any_ovc_granted), 32'(exp_any_ovc), bad);
        for (int n = 0; n < `NOC_PV; n++) begin
            compare($sformatf("granted_ovc_num[%0d]", n), 32'(granted_ovc_num[n]),
                    32'(exp_ovc_num[(n / `NOC_V) * `NOC_V +: `NOC_V]), bad);
        end
        errors += bad;
        rows_checked++;
        if (bad != 0) begin
            rows_failed++;
            $display("row %0d: %0d mismatches", row_id, bad);
        end else begin
            $display("row %0d: ok", row_id);
        end
    endtask

    task automatic check_invariants();
        logic [`NOC_PV-1:0] masked;
        int owners;
        int bad;
        bad = 0;
        for (int n = 0; n < `NOC_PV; n++) begin
            masked[n] = (ivc_req[n] & ovc_is_assigned[n] & assigned_ovc_not_full[n])
                      | (|masked_ovc_request[n]);
        end
        for (int p = 0; p < `NOC_P; p++) begin
            if ($countones(ivc_sw_grant[p*`NOC_V +: `NOC_V]) > 1) begin
                $display("t=%0t input port %0d has more than one IVC granted", $time, p);
                bad++;
            end
        end
        for (int o = 0; o < `NOC_P; o++) begin
            owners = 0;
            for (int i = 0; i < `NOC_P; i++) begin
                // output o sits at bit o below the input and at bit o-1 above it
                if (i != o && granted_dest_port[i][(o < i) ? o : o - 1]) begin
                    owners++;
                end
            end
            if (owners > 1) begin
                $display("t=%0t output port %0d went to %0d input ports", $time, o, owners);
                bad++;
            end
            if (any_ovc_granted[o] != (owners > 0)) begin
                $display("t=%0t any_ovc_granted[%0d] disagrees with the granted destinations",
                         $time, o);
                bad++;
            end
        end
        if ((ivc_sw_grant & ~masked) != '0) begin
            $display("t=%0t a switch grant went to an IVC without a masked request", $time);
            bad++;
        end
        if ((ivc_ovc_grant & ~(ivc_sw_grant & ~ovc_is_assigned)) != '0) begin
            $display("t=%0t an OVC grant went to an IVC that lost or owns an OVC", $time);
            bad++;
        end
        if ($countones(ovc_allocated) != $countones(ivc_ovc_grant)) begin
            $display("t=%0t ovc_allocated does not match the new OVC grants", $time);
            bad++;
        end
        rand_cycles++;
        rand_errors += bad;
        errors += bad;
    endtask

    always begin
        @(posedge clk);
        #7;  // just ahead of the next edge
        if (row_valid) begin
            check_row();
        end
        if (rand_valid) begin
            check_invariants();
        end
    end

    always @(posedge report_req) begin
        $display("rows %0d, failed %0d, random cycles %0d, random errors %0d, total errors %0d",
                 rows_checked, rows_failed, rand_cycles, rand_errors, errors);
    end

endmodule

// File: verif/tb_comb_nonspec_alloc.sv
`include "noc_alloc_config.svh"

module tb_comb_nonspec_alloc;
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct {
        logic [`NOC_PV-1:0]          req;
        logic [`NOC_PV-1:0]          asg;
        logic [`NOC_PV-1:0]          nfull;
        logic [`NOC_PV*`NOC_V-1:0]   ovc;    // nibble per IVC
        logic [`NOC_PV*`NOC_P_1-1:0] dest;   // nibble per IVC
        logic [`NOC_PV-1:0]          sw;
        logic [`NOC_P*`NOC_P_1-1:0]  dport;  // nibble per port
        logic [`NOC_PV-1:0]          ovcg;
        logic [`NOC_P*`NOC_V-1:0]    ovcn;   // nibble per port
        logic [`NOC_PV-1:0]          alloc;
    } row_t;

    localparam int RAND_CYCLES = 200;

    logic                     clk;
    logic                     rst_n;
    noc_vc_pkg::ivc_vec_t     ivc_req;
    noc_vc_pkg::ivc_vec_t     ovc_is_assigned;
    noc_vc_pkg::ivc_vec_t     assigned_ovc_not_full;
    noc_vc_pkg::ovc_mask_t    masked_ovc_request [`NOC_PV];
    noc_port_pkg::dest_port_t dest_port [`NOC_PV];
    noc_vc_pkg::ivc_vec_t     ovc_allocated;
    noc_vc_pkg::vc_vec_t      granted_ovc_num [`NOC_PV];
    noc_vc_pkg::ivc_vec_t     ivc_ovc_grant;
    noc_port_pkg::dest_port_t granted_dest_port [`NOC_P];
    noc_vc_pkg::ivc_vec_t     ivc_sw_grant;
    noc_port_pkg::port_vec_t  any_ivc_granted;
    noc_port_pkg::port_vec_t  any_ovc_granted;

    row_t        table_rows[$];
    row_t        cur;              // row on the DUT inputs right now
    logic        row_valid;
    logic        rand_valid;
    logic        report_req;
    int          row_id;
    int          error_count;
    logic [31:0] lfsr = 32'h1e80b2b5;

    tb_clk_gen clk_gen_inst (.clk(clk), .rst_n(rst_n));

    comb_nonspec_alloc comb_nonspec_alloc_inst (
        .clk(clk), .rst_n(rst_n), .ivc_req(ivc_req), .ovc_is_assigned(ovc_is_assigned),
        .assigned_ovc_not_full(assigned_ovc_not_full), .masked_ovc_request(masked_ovc_request),
        .dest_port(dest_port), .ovc_allocated(ovc_allocated),
        .granted_ovc_num(granted_ovc_num), .ivc_ovc_grant(ivc_ovc_grant),
        .granted_dest_port(granted_dest_port), .ivc_sw_grant(ivc_sw_grant),
        .any_ivc_granted(any_ivc_granted), .any_ovc_granted(any_ovc_granted)
    );

    alloc_checker alloc_checker_inst (
        .clk(clk), .row_valid(row_valid), .rand_valid(rand_valid), .report_req(report_req),
        .row_id(row_id), .ivc_req(ivc_req), .ovc_is_assigned(ovc_is_assigned),
        .assigned_ovc_not_full(assigned_ovc_not_full), .masked_ovc_request(masked_ovc_request),
        .ovc_allocated(ovc_allocated), .granted_ovc_num(granted_ovc_num),
        .ivc_ovc_grant(ivc_ovc_grant), .granted_dest_port(granted_dest_port),
        .ivc_sw_grant(ivc_sw_grant), .any_ivc_granted(any_ivc_granted),
        .any_ovc_granted(any_ovc_granted),
        .exp_sw_grant(cur.sw), .exp_ovc_grant(cur.ovcg), .exp_allocated(cur.alloc),
        .exp_dest_port(cur.dport), .exp_ovc_num(cur.ovcn), .error_count(error_count)
    );

    // value v placed in the nibble of IVC n
    function automatic logic [`NOC_PV*4-1:0] at_ivc(input int n, input logic [3:0] v);
        logic [`NOC_PV*4-1:0] r;
        r = '0;
        r[n*4 +: 4] = v;
        return r;
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // one step per bit, lsb first
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r[i] = lfsr[0];
        end
        return r;
    endfunction

    task automatic add_row(input logic [`NOC_PV-1:0] req, asg, nfull,
                           input logic [`NOC_PV*4-1:0] ovc, dest,
                           input logic [`NOC_PV-1:0] sw, dport, ovcg, ovcn, alloc);
        row_t r;
        r = '{req, asg, nfull, ovc, dest, sw, dport, ovcg, ovcn, alloc};
        table_rows.push_back(r);
    endtask

    task automatic apply_row(input row_t r);
        cur = r;
        ivc_req = r.req;
        ovc_is_assigned = r.asg;
        assigned_ovc_not_full = r.nfull;
        for (int n = 0; n < `NOC_PV; n++) begin
            masked_ovc_request[n] = r.ovc[n*`NOC_V +: `NOC_V];
            dest_port[n] = r.dest[n*`NOC_P_1 +: `NOC_P_1];
        end
    endtask

    // owned OVCs never come with a free-OVC mask in a real router
    task automatic apply_random();
        row_t r;
        r = '{default: '0};
        for (int n = 0; n < `NOC_PV; n++) begin
            r.asg[n] = 1'(take_bits(1));
            r.nfull[n] = 1'(take_bits(1));
            r.req[n] = 1'(take_bits(1));
            if (!r.asg[n] && r.req[n]) begin
                r.ovc[n*4 +: 4] = 4'(take_bits(4));
            end
            r.dest[n*4 +: 4] = 4'b0001 << take_bits(2);
        end
        apply_row(r);
    endtask

    task automatic fill_table();
        logic [`NOC_PV*4-1:0] d_out4;
        logic [`NOC_PV*4-1:0] d_p2;
        logic [`NOC_PV*4-1:0] d_p24;
        d_out4 = at_ivc(4, 4'b1000) | at_ivc(12, 4'b1000);  // ports 1 and 3 both to output 4
        d_p2 = at_ivc(8, 4'b0001) | at_ivc(9, 4'b0001) | at_ivc(10, 4'b0001);
        d_p24 = d_p2 | at_ivc(16, 4'b0001);                  // port 4 also wants output 0
        add_row('0, '0, '0, '0, '0, '0, '0, '0, '0, '0);
        // the candidate arbiter starts at OVC 0 so OVC 1 wins
        add_row(20'h00002, '0, '0, at_ivc(1, 4'b0110), at_ivc(1, 4'b0010),
                20'h00002, 20'h00002, 20'h00002, 20'h00002, 20'h00200);
        add_row(20'h00040, 20'h00040, 20'h00040, '0, at_ivc(6, 4'b0001),
                20'h00040, 20'h00010, '0, '0, '0);
        add_row(20'h00040, 20'h00040, '0, '0, at_ivc(6, 4'b0001), '0, '0, '0, '0, '0);
        // output 4 alternates starting with input 1
        add_row(20'h01010, 20'h01010, 20'h01010, '0, d_out4, 20'h00010, 20'h00080, '0, '0, '0);
        add_row(20'h01010, 20'h01010, 20'h01010, '0, d_out4, 20'h01000, 20'h08000, '0, '0, '0);
        add_row(20'h01010, 20'h01010, 20'h01010, '0, d_out4, 20'h00010, 20'h00080, '0, '0, '0);
        // port 2 keeps IVC 9 after losing output 0 to port 4
        add_row(20'h00700, 20'h00700, 20'h00700, '0, d_p2, 20'h00100, 20'h00100, '0, '0, '0);
        add_row(20'h10700, 20'h10700, 20'h10700, '0, d_p24, 20'h10000, 20'h10000, '0, '0, '0);
        add_row(20'h10700, 20'h10700, 20'h10700, '0, d_p24, 20'h00200, 20'h00100, '0, '0, '0);
        add_row(20'h00700, 20'h00700, 20'h00700, '0, d_p2, 20'h00400, 20'h00100, '0, '0, '0);
        // candidate pointer moved past OVC 1
        add_row(20'h00002, '0, '0, at_ivc(1, 4'b0110), at_ivc(1, 4'b0010),
                20'h00002, 20'h00002, 20'h00002, 20'h00004, 20'h00400);
    endtask

    initial begin
        int waited;
        apply_row('{default: '0});
        row_valid = 1'b0;
        rand_valid = 1'b0;
        report_req = 1'b0;
        row_id = 0;
        fill_table();
        waited = 0;
        while (rst_n !== 1'b1 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (rst_n === 1'b1) begin
            for (int i = 0; i < table_rows.size(); i++) begin
                @(posedge clk);
                #1;
                apply_row(table_rows[i]);
                row_id = i;
                row_valid = 1'b1;
            end
            for (int i = 0; i < RAND_CYCLES; i++) begin
                @(posedge clk);
                #1;
                row_valid = 1'b0;
                apply_random();
                rand_valid = 1'b1;
            end
            @(posedge clk);
            #1;
            rand_valid = 1'b0;
        end else begin
            $display("reset was not released within %0d cycles", waited);
        end
        report_req = 1'b1;
        #1;
        if (rst_n !== 1'b1 || error_count != 0) begin
            $display("SIMULATION FAILED");
        end else begin
            $display("SIMULATION PASSED");
        end
        $finish;
    end

    // whole-run limit
    initial begin
        #20000;
        $display("timeout, the run did not reach its end");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: project.f
+incdir+hw
hw/noc_port_pkg.sv
hw/noc_vc_pkg.sv
hw/rr_arbiter.sv
hw/nonspec_sw_alloc.sv
hw/comb_nonspec_alloc.sv
verif/tb_clk_gen.sv
verif/alloc_checker.sv
verif/tb_comb_nonspec_alloc.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the allocator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f \
    --top-module tb_comb_nonspec_alloc -o sim_tb

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "SIMULATION FAILED" sim.log; then
    echo "run_sim: failure"
    exit 1
fi
echo "run_sim: done"
